//--- fu_status_table.sv
/* functional-unit status table, one row and two source tags per scalar slot
   written by dispatch, tags cleared by writeback, ready vector fed to the scheduler */
`timescale 1ns/1ps
`include "issue_config.svh"

module fu_status_table (
    input logic                CLK,
    input logic                nRST,
    input logic                disp_en,
    input sched_pkg::slot_idx_t disp_fu,
    input isa_pkg::op_row_t    disp_op,
    input sched_pkg::tag_t     disp_t1,
    input sched_pkg::tag_t     disp_t2,
    input logic                wb_en,
    input sched_pkg::tag_t     wb_tag,
    fust_if.tbl                fust
);

    isa_pkg::op_row_t rows_q [`NUM_SLOTS];
    sched_pkg::tag_t  t1_q   [`NUM_SLOTS];
    sched_pkg::tag_t  t2_q   [`NUM_SLOTS];
    // row holds an operation that has not yet gone to execute
    logic [`NUM_SLOTS-1:0] occ_q;

    logic            disp_wr;
    sched_pkg::tag_t t1_in;
    sched_pkg::tag_t t2_in;

    assign disp_wr = disp_en && fust.disp_ok;

    // a writeback on the dispatch edge also satisfies the incoming row
    // otherwise the new row would wait forever on a result already written
    assign t1_in = (wb_en && (disp_t1 == wb_tag)) ? '0 : disp_t1;
    assign t2_in = (wb_en && (disp_t2 == wb_tag)) ? '0 : disp_t2;

    // tags and occupancy
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            occ_q <= '0;
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                t1_q[i] <= '0;
                t2_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                if (disp_wr && (disp_fu == sched_pkg::slot_idx_t'(i))) begin
                    t1_q[i]  <= t1_in;
                    t2_q[i]  <= t2_in;
                    occ_q[i] <= 1'b1;
                end else begin
                    // broadcast clear on older rows
                    if (wb_en && (t1_q[i] == wb_tag)) t1_q[i] <= '0;
                    if (wb_en && (t2_q[i] == wb_tag)) t2_q[i] <= '0;
                    // leaves the table once it moves to execute
                    if (fust.sel[i]) occ_q[i] <= 1'b0;
                end
            end
        end
    end

    // operation payload
    always_ff @(posedge CLK) begin
        if (disp_wr) begin
            rows_q[disp_fu] <= disp_op;
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            fust.rows[i] = rows_q[i];
            fust.rdy[i]  = occ_q[i] && (t1_q[i] == '0) && (t2_q[i] == '0);
        end
    end

    // scheduler must never accept a dispatch over a live row
    a_no_overwrite: assert property (
        @(posedge CLK) disable iff (!nRST)
        disp_wr |-> !occ_q[disp_fu]
    );

endmodule

//--- isa_pkg.sv
/* instruction-level types shared by dispatch, the status table and the register file */
`include "issue_config.svh"

package isa_pkg;

    // register index
    typedef logic [4:0] regbits_t;

    // data word
    typedef logic [`XLEN-1:0] word_t;

    // alu operation code, passed through to execute untouched
    typedef logic [3:0] aluop_t;

    // decoded operation held in one slot row
    typedef struct packed {
        regbits_t rd;
        regbits_t rs1;
        regbits_t rs2;
        word_t    imm;
        // operand b comes from imm instead of rs2
        logic     i_type;
        // operand a forced to zero
        logic     lui;
        aluop_t   alu_op;
    } op_row_t;

endpackage

//--- issue_config.svh
/* sizing macros for the issue stage
   include before any package or module that needs slot, register or width counts */
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// one slot per scalar unit: alu, load/store, branch
`define NUM_SLOTS 3

// architectural integer registers
`define NUM_REGS 32

// data word width
`define XLEN 32

// dispatch sequence counter width
// must hold at least NUM_SLOTS live stamps without aliasing
`define AGE_W 4

`endif

//--- issue_ifs.sv
/* internal buses of the issue stage
   fust_if joins status table and scheduler, rf_if joins top level and register file */
`timescale 1ns/1ps
`include "issue_config.svh"

interface fust_if;
    // scheduler allows a dispatch this cycle
    logic                                 disp_ok;
    // occupied rows with both tags clear
    logic [`NUM_SLOTS-1:0]                rdy;
    // stored operation of every slot
    isa_pkg::op_row_t [`NUM_SLOTS-1:0]    rows;
    // one-hot or zero, slot moving to execute
    logic [`NUM_SLOTS-1:0]                sel;

    modport tbl (input disp_ok, input sel, output rdy, output rows);
    modport sched (output disp_ok, output sel, input rdy);
endinterface

interface rf_if;
    isa_pkg::regbits_t rsel1;
    isa_pkg::regbits_t rsel2;
    logic              wen;
    isa_pkg::regbits_t wsel;
    isa_pkg::word_t    wdata;
    isa_pkg::word_t    rdat1;
    isa_pkg::word_t    rdat2;

    modport rf (input rsel1, rsel2, wen, wsel, wdata, output rdat1, rdat2);
    modport user (output rsel1, rsel2, wen, wsel, wdata, input rdat1, rdat2);
endinterface

//--- issue_scheduler.sv
/* per-slot state machines and oldest-ready selection for the issue stage
   dispatch stamps a sequence number, the ready slot with the oldest stamp goes to execute */
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_scheduler (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  freeze,
    input  logic [`NUM_SLOTS-1:0] fu_done,
    input  logic                  disp_en,
    input  sched_pkg::slot_idx_t  disp_fu,
    fust_if.sched                 fust,
    output logic [`NUM_SLOTS-1:0] busy
);

    sched_pkg::slot_state_e state_q [`NUM_SLOTS];
    sched_pkg::slot_state_e state_d [`NUM_SLOTS];

    logic [`AGE_W-1:0] seq_q;
    logic [`AGE_W-1:0] stamp_q [`NUM_SLOTS];
    logic [`AGE_W-1:0] age     [`NUM_SLOTS];

    logic [`NUM_SLOTS-1:0] disp_hit;
    logic [`NUM_SLOTS-1:0] cand;
    logic                  disp_acc;

    // dispatch allowed into an empty slot, or one finishing on this edge
    assign fust.disp_ok = !freeze &&
        ((state_q[disp_fu] == sched_pkg::SLOT_EMPTY) ||
         ((state_q[disp_fu] == sched_pkg::SLOT_EX) && fu_done[disp_fu]));

    assign disp_acc = disp_en && fust.disp_ok;

    always_comb begin
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            disp_hit[i] = disp_acc && (disp_fu == sched_pkg::slot_idx_t'(i));
            // wrapping distance from the next stamp, larger is older
            age[i]      = seq_q - stamp_q[i];
        end
    end

    // nothing leaves for execute under freeze
    assign cand = fust.rdy & ~{`NUM_SLOTS{freeze}};

    // oldest candidate wins, equal age goes to the lower index
    always_comb begin
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            fust.sel[i] = cand[i];
            for (int j = 0; j < `NUM_SLOTS; j++) begin
                if ((j != i) && cand[j]) begin
                    if ((age[j] > age[i]) || ((age[j] == age[i]) && (j < i))) begin
                        fust.sel[i] = 1'b0;
                    end
                end
            end
        end
    end

    // slot fsm
    always_comb begin
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            state_d[i] = state_q[i];
            case (state_q[i])
                sched_pkg::SLOT_EMPTY: begin
                    if (disp_hit[i]) state_d[i] = sched_pkg::SLOT_WAIT;
                end
                sched_pkg::SLOT_WAIT: begin
                    // a ready row may go straight to execute
                    if (fust.sel[i]) state_d[i] = sched_pkg::SLOT_EX;
                    else if (fust.rdy[i]) state_d[i] = sched_pkg::SLOT_RDY;
                end
                sched_pkg::SLOT_RDY: begin
                    if (fust.sel[i]) state_d[i] = sched_pkg::SLOT_EX;
                end
                sched_pkg::SLOT_EX: begin
                    // unit done, back-to-back dispatch refills the slot
                    if (fu_done[i]) begin
                        state_d[i] = disp_hit[i] ? sched_pkg::SLOT_WAIT
                                                 : sched_pkg::SLOT_EMPTY;
                    end
                end
                default: state_d[i] = sched_pkg::SLOT_EMPTY;
            endcase
            // everything holds while execute is stalled
            if (freeze) state_d[i] = state_q[i];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            seq_q <= '0;
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                state_q[i] <= sched_pkg::SLOT_EMPTY;
            end
        end else begin
            state_q <= state_d;
            if (disp_acc) seq_q <= seq_q + 1'b1;
        end
    end

    // each accepted dispatch records the running sequence number
    always_ff @(posedge CLK) begin
        if (disp_acc) begin
            stamp_q[disp_fu] <= seq_q;
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            busy[i] = (state_q[i] != sched_pkg::SLOT_EMPTY);
        end
    end

    // at most one issue per cycle
    a_sel_valid: assert property (
        @(posedge CLK) disable iff (!nRST)
        $onehot0(fust.sel)
    );

endmodule

//--- issue_stage.sv
/* top level of the scalar issue stage
   status table, scheduler and register file feed a registered issue bundle toward execute */
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_stage (
    input  logic                  CLK,
    input  logic                  nRST,
    // dispatch
    input  logic                  disp_en,
    input  sched_pkg::slot_idx_t  disp_fu,
    input  isa_pkg::op_row_t      disp_op,
    input  sched_pkg::tag_t       disp_t1,
    input  sched_pkg::tag_t       disp_t2,
    // writeback
    input  logic                  wb_en,
    input  isa_pkg::regbits_t     wb_sel,
    input  isa_pkg::word_t        wb_data,
    input  sched_pkg::tag_t       wb_tag,
    // completion and control
    input  logic [`NUM_SLOTS-1:0] fu_done,
    input  logic                  freeze,
    input  logic                  halt_req,
    // toward execute
    output sched_pkg::issue_t     iss,
    output logic [`NUM_SLOTS-1:0] busy,
    output logic                  halt
);

    fust_if fust_bus ();
    rf_if   rf_bus ();

    isa_pkg::op_row_t  row_sel;
    isa_pkg::word_t    opa;
    isa_pkg::word_t    opb;
    sched_pkg::issue_t iss_d;
    logic              halt_q;

    regfile u_regfile (
        .CLK  (CLK),
        .nRST (nRST),
        .rf   (rf_bus)
    );

    fu_status_table u_fust (
        .CLK     (CLK),
        .nRST    (nRST),
        .disp_en (disp_en),
        .disp_fu (disp_fu),
        .disp_op (disp_op),
        .disp_t1 (disp_t1),
        .disp_t2 (disp_t2),
        .wb_en   (wb_en),
        .wb_tag  (wb_tag),
        .fust    (fust_bus)
    );

    issue_scheduler u_sched (
        .CLK     (CLK),
        .nRST    (nRST),
        .freeze  (freeze),
        .fu_done (fu_done),
        .disp_en (disp_en),
        .disp_fu (disp_fu),
        .fust    (fust_bus),
        .busy    (busy)
    );

    // row of the slot going to execute, zero when nothing is selected
    always_comb begin
        row_sel = '0;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            if (fust_bus.sel[i]) row_sel = fust_bus.rows[i];
        end
    end

    // register file hookup, writeback writes and issue reads
    assign rf_bus.wen   = wb_en;
    assign rf_bus.wsel  = wb_sel;
    assign rf_bus.wdata = wb_data;
    assign rf_bus.rsel1 = row_sel.rs1;
    assign rf_bus.rsel2 = row_sel.rs2;

    // operand forming
    assign opa = row_sel.lui    ? '0          : rf_bus.rdat1;
    assign opb = row_sel.i_type ? row_sel.imm : rf_bus.rdat2;

    always_comb begin
        if (freeze) begin
            // execute stalled, hold what it already sees
            iss_d = iss;
        end else begin
            iss_d.fu_en  = fust_bus.sel;
            iss_d.rd     = row_sel.rd;
            iss_d.rdat1  = opa;
            iss_d.rdat2  = opb;
            iss_d.imm    = row_sel.imm;
            iss_d.alu_op = row_sel.alu_op;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            iss <= '0;
        end else begin
            iss <= iss_d;
        end
    end

    // sticky halt request
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            halt_q <= 1'b0;
        end else if (halt_req) begin
            halt_q <= 1'b1;
        end
    end

    // report only once every unit has drained
    assign halt = halt_q && (busy == '0);

endmodule

//--- regfile.sv
/* integer register file, two combinational read ports and one write port
   writes land at the clock edge with no bypass, register 0 always reads zero */
`timescale 1ns/1ps
`include "issue_config.svh"

module regfile (
    input logic CLK,
    input logic nRST,
    rf_if.rf    rf
);

    isa_pkg::word_t regs [`NUM_REGS];

    // write port, r0 is hardwired
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wen && (rf.wsel != '0)) begin
            regs[rf.wsel] <= rf.wdata;
        end
    end

    // read ports
    always_comb begin
        rf.rdat1 = (rf.rsel1 == '0) ? '0 : regs[rf.rsel1];
        rf.rdat2 = (rf.rsel2 == '0) ? '0 : regs[rf.rsel2];
    end

    // writeback from execute must carry a known destination
    a_wsel_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        rf.wen |-> !$isunknown(rf.wsel)
    );

endmodule

//--- run.sh
#!/bin/sh
# build and run the issue stage testbench, the verdict comes from the simulation log
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_issue -f sources.f > build.log 2>&1 &&
    ./obj_dir/Vtb_issue > sim.log 2>&1 ||
    echo "build or simulation ended abnormally, see build.log and sim.log"
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sched_pkg.sv
/* scheduling types for the issue stage
   slot states, source tags and the registered issue bundle */
`include "issue_config.svh"

package sched_pkg;

    // per-slot lifecycle
    typedef enum logic [1:0] {
        SLOT_EMPTY = 2'd0,
        SLOT_WAIT  = 2'd1,
        SLOT_RDY   = 2'd2,
        SLOT_EX    = 2'd3
    } slot_state_e;

    // source tag
    // 0 means operand available, k means unit k-1 still produces it
    typedef logic [1:0] tag_t;

    // slot / unit index
    typedef logic [$clog2(`NUM_SLOTS)-1:0] slot_idx_t;

    // bundle leaving the issue register toward execute
    typedef struct packed {
        // one bit per unit, pulses for one cycle on issue
        logic [`NUM_SLOTS-1:0] fu_en;
        isa_pkg::regbits_t     rd;
        isa_pkg::word_t        rdat1;
        isa_pkg::word_t        rdat2;
        isa_pkg::word_t        imm;
        isa_pkg::aluop_t       alu_op;
    } issue_t;

endpackage

//--- sources.f
+incdir+.
isa_pkg.sv
sched_pkg.sv
issue_ifs.sv
regfile.sv
fu_status_table.sv
issue_scheduler.sv
issue_stage.sv
tb_issue.sv

//--- tb_issue.sv
/* self-checking testbench for the issue stage
   drives dispatch, writeback and control while concurrent assertions compare iss with a scoreboard */
`timescale 1ns/1ps
`include "issue_config.svh"

module tb_issue;

    logic                  CLK;
    logic                  nRST;
    logic                  disp_en;
    sched_pkg::slot_idx_t  disp_fu;
    isa_pkg::op_row_t      disp_op;
    sched_pkg::tag_t       disp_t1;
    sched_pkg::tag_t       disp_t2;
    logic                  wb_en;
    isa_pkg::regbits_t     wb_sel;
    isa_pkg::word_t        wb_data;
    sched_pkg::tag_t       wb_tag;
    logic [`NUM_SLOTS-1:0] fu_done;
    logic                  freeze;
    logic                  halt_req;
    sched_pkg::issue_t     iss;
    logic [`NUM_SLOTS-1:0] busy;
    logic                  halt;

    // reference registers and expected issues in order
    isa_pkg::word_t        ref_regs [`NUM_REGS];
    sched_pkg::issue_t     exp_q [$];
    int                    due_q [$];
    // head of the scoreboard, seen by the assertions
    logic                  exp_valid;
    sched_pkg::issue_t     exp_iss;
    int                    exp_due;
    // rising edges elapsed
    int                    cyc;
    // freeze as sampled at the last edge, iss was held there
    logic                  held_q;
    sched_pkg::issue_t     iss_prev;
    logic [`NUM_SLOTS-1:0] busy_ref;
    logic                  halt_ref;
    int                    val_errs;
    int                    other_errs;
    logic                  fresh;
    logic                  chk;

    issue_stage uut (
        .CLK      (CLK),
        .nRST     (nRST),
        .disp_en  (disp_en),
        .disp_fu  (disp_fu),
        .disp_op  (disp_op),
        .disp_t1  (disp_t1),
        .disp_t2  (disp_t2),
        .wb_en    (wb_en),
        .wb_sel   (wb_sel),
        .wb_data  (wb_data),
        .wb_tag   (wb_tag),
        .fu_done  (fu_done),
        .freeze   (freeze),
        .halt_req (halt_req),
        .iss      (iss),
        .busy     (busy),
        .halt     (halt)
    );

    // 20 ns clock
    always #10 CLK = ~CLK;

    task automatic report_mismatch(input string sig, input logic [127:0] got,
                                   input logic [127:0] want);
        val_errs++;
        $display("Error at %0t: %s is %h, expected %h", $time, sig, got, want);
    endtask

    task automatic report_failure(input string what);
        other_errs++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    function automatic logic [`NUM_SLOTS-1:0] slot_bit(input sched_pkg::slot_idx_t s);
        logic [`NUM_SLOTS-1:0] b;
        b    = '0;
        b[s] = 1'b1;
        return b;
    endfunction

    function automatic isa_pkg::op_row_t make_row(
        input isa_pkg::regbits_t rd, input isa_pkg::regbits_t rs1,
        input isa_pkg::regbits_t rs2, input isa_pkg::word_t imm,
        input logic i_type, input logic lui, input isa_pkg::aluop_t alu_op);
        isa_pkg::op_row_t r;
        r.rd     = rd;
        r.rs1    = rs1;
        r.rs2    = rs2;
        r.imm    = imm;
        r.i_type = i_type;
        r.lui    = lui;
        r.alu_op = alu_op;
        return r;
    endfunction

    function automatic void refresh_head();
        exp_valid = (exp_q.size() > 0);
        exp_iss   = '0;
        exp_due   = 0;
        if (exp_valid) begin
            exp_iss = exp_q[0];
            exp_due = due_q[0];
        end
    endfunction

    // operand rule: lui zeroes a, i-type takes imm as b
    task automatic expect_issue(input sched_pkg::slot_idx_t s, input isa_pkg::op_row_t r,
                                input int due);
        sched_pkg::issue_t e;
        e.fu_en  = slot_bit(s);
        e.rd     = r.rd;
        e.rdat1  = r.lui ? '0 : ref_regs[r.rs1];
        e.rdat2  = r.i_type ? r.imm : ref_regs[r.rs2];
        e.imm    = r.imm;
        e.alu_op = r.alu_op;
        exp_q.push_back(e);
        due_q.push_back(due);
        refresh_head();
    endtask

    // one rising edge, strobes drop unless the caller drives them again
    task automatic step();
        @(posedge CLK);
        disp_en  <= 1'b0;
        wb_en    <= 1'b0;
        fu_done  <= '0;
        halt_req <= 1'b0;
    endtask

    task automatic dispatch(input sched_pkg::slot_idx_t s, input isa_pkg::op_row_t r,
                            input sched_pkg::tag_t t1, input sched_pkg::tag_t t2);
        step();
        disp_en <= 1'b1;
        disp_fu <= s;
        disp_op <= r;
        disp_t1 <= t1;
        disp_t2 <= t2;
    endtask

    task automatic write_reg(input isa_pkg::regbits_t sel, input isa_pkg::word_t data,
                             input sched_pkg::tag_t tag);
        step();
        wb_en   <= 1'b1;
        wb_sel  <= sel;
        wb_data <= data;
        wb_tag  <= tag;
        // r0 stays zero
        if (sel != '0) ref_regs[sel] = data;
    endtask

    task automatic finish_slots(input logic [`NUM_SLOTS-1:0] mask);
        step();
        fu_done <= mask;
    endtask

    // until every expected issue was seen
    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() > 0) && (n < 40)) begin
            step();
            @(negedge CLK);
            n++;
        end
        if (exp_q.size() > 0) begin
            report_failure("timed out waiting for an expected issue");
            exp_q.delete();
            due_q.delete();
            refresh_head();
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((busy != '0) && (n < 20)) begin
            step();
            @(negedge CLK);
            n++;
        end
        if (busy != '0) report_failure("timed out waiting for all slots to drain");
    endtask

    // scoreboard pop, held state and edge count
    always @(posedge CLK) begin
        cyc      <= cyc + 1;
        held_q   <= freeze;
        iss_prev <= iss;
        if (nRST && !held_q && (iss.fu_en != '0) && (exp_q.size() > 0)) begin
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
            refresh_head();
        end
    end

    // busy from the edge after dispatch until done, sticky halt request
    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy_ref <= '0;
            halt_ref <= 1'b0;
        end else begin
            if (halt_req) halt_ref <= 1'b1;
            // freeze holds every slot
            if (!freeze) begin
                busy_ref <= (busy_ref & ~fu_done) | (disp_en ? slot_bit(disp_fu) : '0);
            end
        end
    end

    // iss loaded at the last edge and not held by freeze
    assign fresh = !held_q && (iss.fu_en != '0);
    assign chk   = fresh && exp_valid;

    a_iss_expected: assert property (@(negedge CLK) disable iff (!nRST)
        fresh |-> (exp_valid && (cyc == exp_due)))
        else report_failure("an issue appeared on iss that was not due at this cycle");

    a_iss_on_time: assert property (@(negedge CLK) disable iff (!nRST)
        (exp_valid && (cyc == exp_due)) |-> (iss.fu_en == exp_iss.fu_en))
        else report_mismatch("iss.fu_en", 128'(iss.fu_en), 128'(exp_iss.fu_en));

    a_iss_rd: assert property (@(negedge CLK) disable iff (!nRST)
        chk |-> (iss.rd == exp_iss.rd))
        else report_mismatch("iss.rd", 128'(iss.rd), 128'(exp_iss.rd));

    a_iss_rdat1: assert property (@(negedge CLK) disable iff (!nRST)
        chk |-> (iss.rdat1 == exp_iss.rdat1))
        else report_mismatch("iss.rdat1", 128'(iss.rdat1), 128'(exp_iss.rdat1));

    a_iss_rdat2: assert property (@(negedge CLK) disable iff (!nRST)
        chk |-> (iss.rdat2 == exp_iss.rdat2))
        else report_mismatch("iss.rdat2", 128'(iss.rdat2), 128'(exp_iss.rdat2));

    a_iss_imm: assert property (@(negedge CLK) disable iff (!nRST)
        chk |-> (iss.imm == exp_iss.imm))
        else report_mismatch("iss.imm", 128'(iss.imm), 128'(exp_iss.imm));

    a_iss_alu_op: assert property (@(negedge CLK) disable iff (!nRST)
        chk |-> (iss.alu_op == exp_iss.alu_op))
        else report_mismatch("iss.alu_op", 128'(iss.alu_op), 128'(exp_iss.alu_op));

    // execute stalled, the bundle must not move
    a_freeze_hold: assert property (@(negedge CLK) disable iff (!nRST)
        held_q |-> (iss == iss_prev))
        else report_mismatch("iss", 128'(iss), 128'(iss_prev));

    a_busy: assert property (@(negedge CLK) disable iff (!nRST)
        busy == busy_ref)
        else report_mismatch("busy", 128'(busy), 128'(busy_ref));

    a_halt: assert property (@(negedge CLK) disable iff (!nRST)
        halt == (halt_ref && (busy_ref == '0)))
        else report_mismatch("halt", 128'(halt), 128'(halt_ref && (busy_ref == '0)));

    initial begin
        isa_pkg::op_row_t ra;
        isa_pkg::op_row_t rb;
        int               i;
        void'($urandom(32'h8e9a6cc0));
        CLK        = 1'b0;
        nRST       = 1'b0;
        disp_en    = 1'b0;
        disp_fu    = '0;
        disp_op    = '0;
        disp_t1    = '0;
        disp_t2    = '0;
        wb_en      = 1'b0;
        wb_sel     = '0;
        wb_data    = '0;
        wb_tag     = '0;
        fu_done    = '0;
        freeze     = 1'b0;
        halt_req   = 1'b0;
        cyc        = 0;
        held_q     = 1'b0;
        iss_prev   = '0;
        val_errs   = 0;
        other_errs = 0;
        for (i = 0; i < `NUM_REGS; i++) ref_regs[i] = '0;
        refresh_head();
        repeat (3) @(posedge CLK);
        nRST <= 1'b1;

        // clear tags, operands from earlier writebacks
        for (i = 1; i < 5; i++) write_reg(isa_pkg::regbits_t'(i), $urandom, '0);
        ra = make_row(5'd5, 5'd1, 5'd2, $urandom, 1'b0, 1'b0, 4'd3);
        dispatch(2'd0, ra, '0, '0);
        expect_issue(2'd0, ra, cyc + 3);
        wait_drain();
        finish_slots(slot_bit(2'd0));

        // rs1 waits on the alu, tag 1
        ra = make_row(5'd6, 5'd7, 5'd3, $urandom, 1'b0, 1'b0, 4'd5);
        dispatch(2'd1, ra, 2'd1, '0);
        repeat (4) step();
        write_reg(5'd7, $urandom, 2'd1);
        expect_issue(2'd1, ra, cyc + 3);
        wait_drain();
        finish_slots(slot_bit(2'd1));

        // higher slot dispatched first so age beats index
        ra = make_row(5'd9, 5'd1, 5'd8, $urandom, 1'b0, 1'b0, 4'd1);
        rb = make_row(5'd10, 5'd8, 5'd4, $urandom, 1'b0, 1'b0, 4'd2);
        dispatch(2'd2, ra, '0, 2'd2);
        dispatch(2'd0, rb, 2'd2, '0);
        repeat (2) step();
        write_reg(5'd8, $urandom, 2'd2);
        expect_issue(2'd2, ra, cyc + 3);
        expect_issue(2'd0, rb, cyc + 4);
        wait_drain();
        finish_slots(slot_bit(2'd2) | slot_bit(2'd0));

        // lui with i-type, then reads of r0 after a write to it
        write_reg('0, $urandom, '0);
        ra = make_row(5'd11, 5'd3, 5'd4, $urandom, 1'b1, 1'b1, 4'd7);
        rb = make_row(5'd12, 5'd0, 5'd0, $urandom, 1'b0, 1'b0, 4'd8);
        dispatch(2'd0, ra, '0, '0);
        expect_issue(2'd0, ra, cyc + 3);
        dispatch(2'd1, rb, '0, '0);
        expect_issue(2'd1, rb, cyc + 3);
        wait_drain();
        finish_slots(slot_bit(2'd0) | slot_bit(2'd1));

        // freeze lands right after the first issue, second row waits
        ra = make_row(5'd13, 5'd2, 5'd3, $urandom, 1'b0, 1'b0, 4'd9);
        rb = make_row(5'd14, 5'd4, 5'd1, $urandom, 1'b1, 1'b0, 4'd10);
        dispatch(2'd0, ra, '0, '0);
        expect_issue(2'd0, ra, cyc + 3);
        dispatch(2'd1, rb, '0, '0);
        step();
        freeze <= 1'b1;
        repeat (4) step();
        step();
        freeze <= 1'b0;
        expect_issue(2'd1, rb, cyc + 2);
        wait_drain();
        finish_slots(slot_bit(2'd0) | slot_bit(2'd1));

        // halt waits for the branch slot to finish
        ra = make_row(5'd15, 5'd1, 5'd2, $urandom, 1'b0, 1'b0, 4'd11);
        dispatch(2'd2, ra, '0, '0);
        expect_issue(2'd2, ra, cyc + 3);
        wait_drain();
        step();
        halt_req <= 1'b1;
        repeat (3) step();
        finish_slots(slot_bit(2'd2));
        wait_idle();
        repeat (4) step();

        $display("checks done: %0d value errors, %0d other errors", val_errs, other_errs);
        if ((val_errs == 0) && (other_errs == 0)) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
